// File: src/vidcap_pkg.sv
`default_nettype none

package vidcap_pkg;

  localparam int PIXEL_W = 24;
  localparam int DEPTH_W = 16;
  localparam int DROP_W  = 14;

  localparam logic [3:0] WB_ADR_STATUS = 4'd0;
  localparam logic [3:0] WB_ADR_PIXEL  = 4'd1;

  // ========================================
  // Video and FIFO sides
  // ========================================

  typedef struct packed {
    logic [PIXEL_W-1:0] rgb;
    logic               h_sync;
    logic               h_blank;
    logic               v_sync;
    logic               v_blank;
    logic               data_en;
  } video_bus_t;

  // rel is the one-cycle release pulse, sent with act still high
  typedef struct packed {
    logic [1:0]         act;
    logic               stb;
    logic [PIXEL_W-1:0] data;
    logic               rel;
  } ppfifo_wr_t;

  typedef struct packed {
    logic [1:0]         rdy;
    logic [DEPTH_W-1:0] size;
    logic [PIXEL_W-1:0] data;
  } ppfifo_rd_t;

  // ========================================
  // Wishbone host port
  // ========================================

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [3:0]  adr;
    logic [31:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  typedef struct packed {
    logic               valid;
    logic               buf_sel;
    logic [DROP_W-1:0]  drop_count;
    logic [DEPTH_W-1:0] count;
  } status_t;

  typedef struct packed {
    logic [7:0]         zero;
    logic [PIXEL_W-1:0] rgb;
  } pixel_t;

  // Same read word, meaning picked by address
  typedef union packed {
    status_t status;
    pixel_t  pixel;
  } wb_word_u;

endpackage

`default_nettype wire

// File: src/rgb_to_ppfifo.sv
`default_nettype none

module rgb_to_ppfifo import vidcap_pkg::*; #(
  parameter int PIXEL_WIDTH = PIXEL_W,
  parameter int FIFO_DEPTH  = 64
) (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire video_bus_t        i_video,
  input  wire logic [1:0]        i_wr_rdy,
  output ppfifo_wr_t             o_wr,
  output logic [DROP_W-1:0]      o_drop_count
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ACTIVE,
    ST_RELEASE
  } state_t;

  state_t                 state;
  logic [DEPTH_W-1:0]     count;
  logic [1:0]             act_q;
  logic                   stb_q;
  logic                   rel_q;
  logic [PIXEL_WIDTH-1:0] data_q;
  logic [DROP_W-1:0]      drop_q;
  logic [1:0]             claim;
  logic                   drop;

  // Buffer 0 wins when both are empty
  always_comb begin
    if (i_wr_rdy[0]) begin
      claim = 2'b01;
    end else if (i_wr_rdy[1]) begin
      claim = 2'b10;
    end else begin
      claim = 2'b00;
    end
  end

  // No buffer held means the pixel is lost
  assign drop = i_video.data_en && (state != ST_ACTIVE);

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= ST_IDLE;
      count  <= '0;
      act_q  <= 2'b00;
      stb_q  <= 1'b0;
      rel_q  <= 1'b0;
      drop_q <= '0;
    end else begin
      stb_q <= 1'b0;
      rel_q <= 1'b0;
      if (drop && (drop_q != '1)) begin
        drop_q <= drop_q + 1'b1;
      end
      case (state)
        ST_IDLE: begin
          if (claim != 2'b00) begin
            act_q <= claim;
            count <= '0;
            state <= ST_ACTIVE;
          end
        end
        ST_ACTIVE: begin
          if (i_video.data_en) begin
            stb_q <= 1'b1;
            count <= count + 1'b1;
            // Last word goes out together with the release
            if (count == DEPTH_W'(FIFO_DEPTH - 1)) begin
              rel_q <= 1'b1;
              state <= ST_RELEASE;
            end
          end else if (i_video.h_blank && (count != '0)) begin
            rel_q <= 1'b1;
            state <= ST_RELEASE;
          end
        end
        ST_RELEASE: begin
          // Old claim ends on this edge, hand over at once if possible
          act_q <= claim;
          count <= '0;
          state <= (claim != 2'b00) ? ST_ACTIVE : ST_IDLE;
        end
        default: begin
          act_q <= 2'b00;
          state <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (i_video.data_en) begin
      data_q <= i_video.rgb;
    end
  end

  always_comb begin
    o_wr.act  = act_q;
    o_wr.stb  = stb_q;
    o_wr.data = data_q;
    o_wr.rel  = rel_q;
  end

  assign o_drop_count = drop_q;

endmodule

`default_nettype wire

// File: src/ppfifo.sv
`default_nettype none

module ppfifo import vidcap_pkg::*; #(
  parameter int PIXEL_WIDTH = PIXEL_W,
  parameter int FIFO_DEPTH  = 64
) (
  input  wire logic       clk,
  input  wire logic       rst,
  input  wire ppfifo_wr_t i_wr,
  output logic [1:0]      o_wr_rdy,
  input  wire logic [1:0] i_rd_act,
  input  wire logic       i_rd_stb,
  input  wire logic       i_rd_release,
  output ppfifo_rd_t      o_rd
);

  localparam int ADDR_W = $clog2(FIFO_DEPTH);

  typedef enum logic [1:0] {
    BUF_EMPTY,
    BUF_WRITING,
    BUF_FULL,
    BUF_READING
  } buf_state_t;

  buf_state_t             state [2];
  logic [DEPTH_W-1:0]     count [2];
  logic [1:0]             wr_en;
  logic [ADDR_W-1:0]      rd_ptr;
  logic                   rd_sel;
  logic [PIXEL_WIDTH-1:0] mem [2][FIFO_DEPTH];

  // ========================================
  // Write side
  // ========================================

  always_comb begin
    for (int b = 0; b < 2; b++) begin
      wr_en[b] = i_wr.act[b] && i_wr.stb && (state[b] == BUF_WRITING) &&
                 (count[b] < DEPTH_W'(FIFO_DEPTH));
      o_wr_rdy[b] = (state[b] == BUF_EMPTY) && !i_wr.act[b];
    end
  end

  always_ff @(posedge clk) begin
    for (int b = 0; b < 2; b++) begin
      if (wr_en[b]) begin
        mem[b][count[b][ADDR_W-1:0]] <= i_wr.data;
      end
    end
  end

  // ========================================
  // Buffer states and fill counts
  // ========================================

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int b = 0; b < 2; b++) begin
        state[b] <= BUF_EMPTY;
        count[b] <= '0;
      end
    end else begin
      for (int b = 0; b < 2; b++) begin
        case (state[b])
          BUF_EMPTY: begin
            if (i_wr.act[b]) begin
              state[b] <= BUF_WRITING;
            end
          end
          BUF_WRITING: begin
            // A write in the release cycle still lands in the count
            if (wr_en[b]) begin
              count[b] <= count[b] + 1'b1;
            end
            if (i_wr.act[b] && i_wr.rel) begin
              state[b] <= BUF_FULL;
            end
          end
          BUF_FULL: begin
            if (i_rd_act[b]) begin
              state[b] <= BUF_READING;
            end
          end
          BUF_READING: begin
            if (i_rd_act[b] && i_rd_release) begin
              state[b] <= BUF_EMPTY;
              count[b] <= '0;
            end
          end
          default: begin
            state[b] <= BUF_EMPTY;
            count[b] <= '0;
          end
        endcase
      end
    end
  end

  // ========================================
  // Read side
  // ========================================

  // Only one buffer is read at a time so one pointer serves both
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
    end else if (i_rd_release) begin
      rd_ptr <= '0;
    end else if (i_rd_stb && (i_rd_act != 2'b00)) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  assign rd_sel = i_rd_act[1];

  always_comb begin
    for (int b = 0; b < 2; b++) begin
      o_rd.rdy[b] = (state[b] == BUF_FULL);
    end
    o_rd.size = count[rd_sel];
    o_rd.data = mem[rd_sel][rd_ptr];
  end

endmodule

`default_nettype wire

// File: src/ppfifo_wb_reader.sv
`default_nettype none

module ppfifo_wb_reader import vidcap_pkg::*; #(
  parameter int FIFO_DEPTH = 64
) (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire wb_req_t           i_wb,
  output wb_rsp_t                o_wb,
  input  wire ppfifo_rd_t        i_rd,
  output logic [1:0]             o_rd_act,
  output logic                   o_rd_stb,
  output logic                   o_rd_release,
  input  wire logic [DROP_W-1:0] i_drop_count
);

  localparam int POP_W = $clog2(FIFO_DEPTH + 1);

  logic               req_q;
  logic               ack_q;
  logic [31:0]        dat_q;
  logic [POP_W-1:0]   pop_count;
  logic               held;
  logic               new_req;
  logic               pop;
  logic               last_pop;
  logic [DEPTH_W-1:0] remaining;
  wb_word_u           word;

  assign held      = (o_rd_act != 2'b00);
  assign remaining = held ? (i_rd.size - DEPTH_W'(pop_count)) : '0;

  // Master holds the request until ack, so block a restart while busy
  assign new_req  = i_wb.cyc && i_wb.stb && !req_q && !ack_q;
  assign pop      = req_q && !i_wb.we && (i_wb.adr == WB_ADR_PIXEL) && held &&
                    (remaining != '0);
  assign last_pop = pop && (remaining == DEPTH_W'(1));

  // ========================================
  // Read word
  // ========================================

  always_comb begin
    word = '0;
    if (!i_wb.we) begin
      if (i_wb.adr == WB_ADR_STATUS) begin
        word.status.valid      = held;
        word.status.buf_sel    = o_rd_act[1];
        word.status.drop_count = i_drop_count;
        word.status.count      = remaining;
      end else if ((i_wb.adr == WB_ADR_PIXEL) && held && (remaining != '0)) begin
        word.pixel.rgb = i_rd.data;
      end
    end
  end

  // ========================================
  // Ack pipeline and buffer claim
  // ========================================

  always_ff @(posedge clk) begin
    if (rst) begin
      req_q        <= 1'b0;
      ack_q        <= 1'b0;
      o_rd_act     <= 2'b00;
      o_rd_stb     <= 1'b0;
      o_rd_release <= 1'b0;
      pop_count    <= '0;
    end else begin
      req_q        <= new_req;
      ack_q        <= req_q;
      o_rd_stb     <= pop;
      o_rd_release <= last_pop;
      if (o_rd_release) begin
        o_rd_act  <= 2'b00;
        pop_count <= '0;
      end else if (!held) begin
        pop_count <= '0;
        if (i_rd.rdy[0]) begin
          o_rd_act <= 2'b01;
        end else if (i_rd.rdy[1]) begin
          o_rd_act <= 2'b10;
        end
      end else if (pop) begin
        pop_count <= pop_count + 1'b1;
      end
    end
  end

  // Word is taken before the pop moves the pointer
  always_ff @(posedge clk) begin
    if (req_q) begin
      dat_q <= word;
    end
  end

  always_comb begin
    o_wb.ack = ack_q;
    o_wb.dat = dat_q;
  end

endmodule

`default_nettype wire

// File: src/vidcap_top.sv
`default_nettype none

module vidcap_top import vidcap_pkg::*; #(
  parameter int PIXEL_WIDTH = PIXEL_W,
  parameter int FIFO_DEPTH  = 64
) (
  input  wire logic       clk,
  input  wire logic       rst,
  input  wire video_bus_t i_video,
  input  wire wb_req_t    i_wb,
  output wb_rsp_t         o_wb
);

  ppfifo_wr_t        wr;
  logic [1:0]        wr_rdy;
  ppfifo_rd_t        rd;
  logic [1:0]        rd_act;
  logic              rd_stb;
  logic              rd_release;
  logic [DROP_W-1:0] drop_count;

  // ========================================
  // Capture, buffer, host port
  // ========================================

  rgb_to_ppfifo #(
    .PIXEL_WIDTH (PIXEL_WIDTH),
    .FIFO_DEPTH  (FIFO_DEPTH)
  ) u_capture (
    .clk          (clk),
    .rst          (rst),
    .i_video      (i_video),
    .i_wr_rdy     (wr_rdy),
    .o_wr         (wr),
    .o_drop_count (drop_count)
  );

  ppfifo #(
    .PIXEL_WIDTH (PIXEL_WIDTH),
    .FIFO_DEPTH  (FIFO_DEPTH)
  ) u_fifo (
    .clk          (clk),
    .rst          (rst),
    .i_wr         (wr),
    .o_wr_rdy     (wr_rdy),
    .i_rd_act     (rd_act),
    .i_rd_stb     (rd_stb),
    .i_rd_release (rd_release),
    .o_rd         (rd)
  );

  ppfifo_wb_reader #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_reader (
    .clk          (clk),
    .rst          (rst),
    .i_wb         (i_wb),
    .o_wb         (o_wb),
    .i_rd         (rd),
    .o_rd_act     (rd_act),
    .o_rd_stb     (rd_stb),
    .o_rd_release (rd_release),
    .i_drop_count (drop_count)
  );

endmodule

`default_nettype wire

// File: tb/tb_clkgen.sv
`default_nettype none

module tb_clkgen #(
  parameter int HALF_PERIOD  = 20,
  parameter int RESET_CYCLES = 8
) (
  output logic o_clk,
  output logic o_rst
);

  initial begin
    o_clk = 1'b0;
    forever #HALF_PERIOD o_clk = ~o_clk;
  end

  // Reset drops a little after a rising edge, like every other input
  initial begin
    o_rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clk);
    #2 o_rst = 1'b0;
  end

endmodule

`default_nettype wire

// File: tb/tb_vidcap_checker.sv
`default_nettype none

module tb_vidcap_checker import vidcap_pkg::*; (
  input wire logic    clk,
  input wire logic    rst,
  input wire wb_req_t i_req,
  input wire wb_rsp_t i_wb
);

  localparam int KIND_SKIP   = 0;
  localparam int KIND_STATUS = 1;
  localparam int KIND_PIXEL  = 2;
  localparam int KIND_ZERO   = 3;

  logic [31:0] pixel_q [$];
  logic [31:0] exp_q [$];
  int          kind_q [$];
  int          error_count = 0;
  int          check_count = 0;
  int          test_count  = 0;
  int          test_errors = 0;
  int          test_checks = 0;
  int          req_cycles  = 0;

  task automatic push_pixel(input logic [PIXEL_W-1:0] px);
    pixel_q.push_back({8'h00, px});
  endtask

  // One entry per Wishbone cycle in issue order
  task automatic expect_read(input int kind, input logic [31:0] exp);
    kind_q.push_back(kind);
    exp_q.push_back(exp);
  endtask

  task automatic compare_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    check_count++;
    test_checks++;
    if (act !== exp) begin
      error_count++;
      test_errors++;
      $display("** Error at time %0t: %s expected %08h actual %08h", $time, name, exp, act);
    end
  endtask

  task automatic note_failure(input string msg);
    error_count++;
    test_errors++;
    $display("Failure at time %0t: %s", $time, msg);
  endtask

  // ========================================
  // Ack monitor
  // ========================================

  always @(posedge clk) begin : ack_check
    int          kind;
    logic [31:0] exp;
    if (!rst && i_wb.ack) begin
      if (kind_q.size() == 0) begin
        note_failure("acknowledge seen with no cycle outstanding");
      end else begin
        kind = kind_q.pop_front();
        exp  = exp_q.pop_front();
        if (kind == KIND_STATUS) begin
          compare_word("o_wb.dat (status)", exp, i_wb.dat);
        end else if (kind == KIND_ZERO) begin
          compare_word("o_wb.dat (empty pixel)", 32'h0, i_wb.dat);
        end else if (kind == KIND_PIXEL) begin
          if (pixel_q.size() == 0) begin
            note_failure("pixel read returned with no pixel left to expect");
          end else begin
            compare_word("o_wb.dat (pixel)", pixel_q.pop_front(), i_wb.dat);
          end
        end
      end
    end
  end

  // Edges with the request up before its ack shows
  always @(posedge clk) begin : ack_latency
    if (rst) begin
      req_cycles = 0;
    end else if (i_wb.ack) begin
      if (req_cycles != 2) begin
        note_failure($sformatf("acknowledge came after %0d request cycles instead of 2",
                               req_cycles));
      end
      req_cycles = 0;
    end else if (i_req.cyc && i_req.stb) begin
      req_cycles++;
    end
  end

  task automatic end_test(input int num);
    if (pixel_q.size() != 0) begin
      note_failure($sformatf("%0d captured pixels were never read back", pixel_q.size()));
      pixel_q.delete();
    end
    test_count++;
    $display("Test %0d: %0d checks, %0d errors, %s", num, test_checks, test_errors,
             (test_errors == 0) ? "ok" : "failed");
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic report();
    $display("Totals: %0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
  endtask

endmodule

`default_nettype wire

// File: tb/tb_vidcap.sv
`default_nettype none

module tb_vidcap import vidcap_pkg::*; ();

  localparam int FIFO_DEPTH = 64;
  localparam int NUM_TESTS  = 6;
  localparam int WAIT_LIMIT = 200;

  typedef struct packed {
    logic [15:0] line_len;
    logic [15:0] hblank;
    logic [15:0] n_lines;
    logic [15:0] drop_lines;
    logic [15:0] n_bufs;
    logic        sel0;
    logic [15:0] cnt0;
    logic        sel1;
    logic [15:0] cnt1;
    logic [15:0] exp_drop;
    logic        probe_pixel;
    logic        do_write;
  } test_entry_t;

  wire logic   clk;
  wire logic   rst;
  video_bus_t  video;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  test_entry_t tests [NUM_TESTS];
  logic [31:0] lcg_state;

  tb_clkgen u_clkgen (
    .o_clk (clk),
    .o_rst (rst)
  );

  vidcap_top #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_dut (
    .clk     (clk),
    .rst     (rst),
    .i_video (video),
    .i_wb    (wb_req),
    .o_wb    (wb_rsp)
  );

  tb_vidcap_checker u_chk (
    .clk   (clk),
    .rst   (rst),
    .i_req (wb_req),
    .i_wb  (wb_rsp)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic test_entry_t make_entry(
    input int line_len, input int hblank, input int n_lines, input int drop_lines,
    input int n_bufs, input int sel0, input int cnt0, input int sel1, input int cnt1,
    input int exp_drop, input int probe_pixel, input int do_write);
    test_entry_t e;
    e.line_len    = 16'(line_len);
    e.hblank      = 16'(hblank);
    e.n_lines     = 16'(n_lines);
    e.drop_lines  = 16'(drop_lines);
    e.n_bufs      = 16'(n_bufs);
    e.sel0        = sel0[0];
    e.cnt0        = 16'(cnt0);
    e.sel1        = sel1[0];
    e.cnt1        = 16'(cnt1);
    e.exp_drop    = 16'(exp_drop);
    e.probe_pixel = probe_pixel[0];
    e.do_write    = do_write[0];
    return e;
  endfunction

  function automatic logic [31:0] status_word(input logic valid, input logic sel,
                                              input int drop, input int cnt);
    status_t s;
    s.valid      = valid;
    s.buf_sel    = sel;
    s.drop_count = drop[DROP_W-1:0];
    s.count      = cnt[DEPTH_W-1:0];
    return s;
  endfunction

  task automatic abort_run(input string msg);
    $display("Failure at time %0t: %s", $time, msg);
    $display(">>> FAIL");
    $finish;
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  // ========================================
  // Wishbone master
  // ========================================

  task automatic wb_cycle(input logic we, input logic [3:0] adr, input logic [31:0] wdat,
                          input int kind, input logic [31:0] exp, output logic [31:0] rdat);
    bit got;
    got = 0;
    u_chk.expect_read(kind, exp);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = wdat;
    for (int n = 0; n < WAIT_LIMIT && !got; n++) begin
      @(posedge clk);
      #1;
      got = wb_rsp.ack;
    end
    if (!got) begin
      abort_run("no Wishbone acknowledge within 200 cycles");
    end else begin
      rdat = wb_rsp.dat;
      #1;
      wb_req = '0;
      next_cycle();
    end
  endtask

  task automatic wait_status_valid();
    logic [31:0] dat;
    bit          found;
    found = 0;
    for (int n = 0; n < WAIT_LIMIT && !found; n++) begin
      wb_cycle(1'b0, WB_ADR_STATUS, 32'h0, u_chk.KIND_SKIP, 32'h0, dat);
      found = dat[31];
    end
    if (!found) begin
      abort_run("status never showed a held buffer");
    end
  endtask

  // ========================================
  // Video line driver
  // ========================================

  task automatic send_line(input int len, input int hblank, input bit keep);
    for (int i = 0; i < len; i++) begin
      lcg_state = lcg_next(lcg_state);
      video.rgb     = lcg_state[31:8];
      video.data_en = 1'b1;
      video.h_blank = 1'b0;
      // Pixel past a full buffer falls in the claim gap
      if (keep && !(len > FIFO_DEPTH && i == FIFO_DEPTH)) begin
        u_chk.push_pixel(lcg_state[31:8]);
      end
      next_cycle();
    end
    video.data_en = 1'b0;
    video.h_blank = 1'b1;
    for (int i = 0; i < hblank; i++) begin
      video.h_sync = (i == 1);
      next_cycle();
    end
    video.h_sync = 1'b0;
  endtask

  task automatic run_test(input int idx);
    test_entry_t t;
    logic [31:0] dat;
    logic        sel;
    int          cnt;
    t = tests[idx];
    for (int l = 0; l < t.n_lines; l++) begin
      send_line(t.line_len, t.hblank, l < (t.n_lines - t.drop_lines));
    end
    for (int b = 0; b < t.n_bufs; b++) begin
      sel = (b == 0) ? t.sel0 : t.sel1;
      cnt = (b == 0) ? t.cnt0 : t.cnt1;
      wait_status_valid();
      wb_cycle(1'b0, WB_ADR_STATUS, 32'h0, u_chk.KIND_STATUS,
               status_word(1'b1, sel, t.exp_drop, cnt), dat);
      for (int k = 0; k < cnt; k++) begin
        wb_cycle(1'b0, WB_ADR_PIXEL, 32'h0, u_chk.KIND_PIXEL, 32'h0, dat);
      end
    end
    wb_cycle(1'b0, WB_ADR_STATUS, 32'h0, u_chk.KIND_STATUS,
             status_word(1'b0, 1'b0, t.exp_drop, 0), dat);
    if (t.do_write) begin
      wb_cycle(1'b1, WB_ADR_PIXEL, 32'h5a5a_1234, u_chk.KIND_SKIP, 32'h0, dat);
      wb_cycle(1'b0, WB_ADR_STATUS, 32'h0, u_chk.KIND_STATUS,
               status_word(1'b0, 1'b0, t.exp_drop, 0), dat);
    end
    if (t.probe_pixel) begin
      wb_cycle(1'b0, WB_ADR_PIXEL, 32'h0, u_chk.KIND_ZERO, 32'h0, dat);
    end
    u_chk.end_test(idx + 1);
  endtask

  initial begin
    bit released;
    video     = '0;
    wb_req    = '0;
    lcg_state = 32'd45;
    released  = 0;
    // Line, blank, lines, dropped lines, buffers, sel/count pairs, drop, probe, write
    tests[0] = make_entry(0,   6, 0, 0, 0, 0, 0,  0, 0,  0,  1, 0);
    tests[1] = make_entry(40,  6, 1, 0, 1, 0, 40, 0, 0,  0,  1, 0);
    tests[2] = make_entry(100, 6, 1, 0, 2, 1, 64, 0, 35, 1,  0, 0);
    tests[3] = make_entry(24,  6, 2, 0, 2, 1, 24, 0, 24, 1,  0, 0);
    tests[4] = make_entry(16,  6, 3, 1, 2, 1, 16, 0, 16, 17, 0, 0);
    tests[5] = make_entry(0,   6, 0, 0, 0, 0, 0,  0, 0,  17, 1, 1);
    for (int n = 0; n < WAIT_LIMIT && !released; n++) begin
      @(posedge clk);
      released = !rst;
    end
    if (!released) begin
      abort_run("reset never deasserted");
    end else begin
      repeat (4) next_cycle();
      for (int i = 0; i < NUM_TESTS; i++) begin
        run_test(i);
      end
      u_chk.report();
      if (u_chk.error_count == 0) begin
        $display(">>> PASS");
      end else begin
        $display(">>> FAIL");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: vidcap_top.f
src/vidcap_pkg.sv
src/rgb_to_ppfifo.sv
src/ppfifo.sv
src/ppfifo_wb_reader.sv
src/vidcap_top.sv
tb/tb_clkgen.sv
tb/tb_vidcap_checker.sv
tb/tb_vidcap.sv
